// File: Makefile
TOP := tb_sparse_matrix_decoder

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '** PASS **' sim.log

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: command_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "sparse_decoder_consts.svh"

module command_decoder #(
    parameter int PE_ID = 0
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`SMD_DATA_W-1:0]   op,
    input  wire                     idx_done,
    input  wire                     val_done,
    fetch_port_if.monitor           port_a,
    fetch_port_if.monitor           port_b,
    output smac_pkg::reg_load_t     load,
    output logic                    streaming,
    output logic                    busy,
    output logic                    soft_rst
);
    import smac_pkg::*;

    localparam int PE_W = `SMD_OP_ARG_1 - 1 - `SMD_OP_ARG_PE;

    typedef enum logic {
        S_IDLE,
        S_STEADY
    } state_t;

    state_t          state;
    opcode_t         opcode;
    logic [PE_W-1:0] pe_field;
    logic            broadcast;
    logic            active;
    logic            all_done;

    assign opcode    = opcode_t'(op[`SMD_OP_ARG_PE-1:0]);
    assign pe_field  = op[`SMD_OP_ARG_1-2:`SMD_OP_ARG_PE];
    assign broadcast = op[`SMD_OP_ARG_1-1];
    assign active    = broadcast || (pe_field == PE_W'(PE_ID));

    // both streams fetched and both outputs drained
    assign all_done = port_a.at_end && port_b.at_end && idx_done && val_done;

    assign busy = state == S_STEADY;
    // no new requests in the last steady cycle
    assign streaming = busy && !all_done;

    always_ff @(posedge clk) begin
        load.sel   <= reg_sel_t'(op[`SMD_OP_ARG_2-1:`SMD_OP_ARG_1]);
        load.value <= op[`SMD_DATA_W-1:`SMD_OP_ARG_2];
        if (rst) begin
            state      <= S_IDLE;
            load.valid <= 1'b0;
            soft_rst   <= 1'b0;
        end else begin
            load.valid <= active && opcode == OP_LD;
            soft_rst   <= active && opcode == OP_RST;
            if (active && opcode == OP_RST) begin
                state <= S_IDLE;
            end else if (active && opcode == OP_STEADY) begin
                state <= S_STEADY;
            end else if (state == S_STEADY && all_done) begin
                state <= S_IDLE;
            end
        end
    end

endmodule

`default_nettype wire

// File: fetch_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "sparse_decoder_consts.svh"

module fetch_arbiter (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 req_mem_stall,
    fetch_port_if.arbiter       port_a,
    fetch_port_if.arbiter       port_b,
    output logic                req_mem_ld,
    output smac_pkg::mem_addr_t req_mem_addr,
    output smac_pkg::mem_tag_t  req_mem_tag
);
    import smac_pkg::*;

    localparam int SW = $clog2(`SMD_SLICE_CYCLES);

    mem_tag_t  owner;
    logic [SW-1:0] slice_cnt;
    logic      hold;
    logic      want_own;
    logic      want_other;
    logic      slice_over;
    logic      issue;
    mem_addr_t own_addr;

    // pending request not taken by memory
    assign hold = req_mem_ld && req_mem_stall;

    assign want_own   = (owner == TAG_INDEX) ? port_a.want : port_b.want;
    assign want_other = (owner == TAG_INDEX) ? port_b.want : port_a.want;
    assign own_addr   = (owner == TAG_INDEX) ? port_a.addr : port_b.addr;
    assign slice_over = slice_cnt == SW'(`SMD_SLICE_CYCLES - 1);

    assign issue        = want_own && !hold;
    assign port_a.grant = issue && owner == TAG_INDEX;
    assign port_b.grant = issue && owner == TAG_VALUE;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_mem_ld <= 1'b0;
            owner      <= TAG_INDEX;
            slice_cnt  <= '0;
        end else begin
            if (!hold) begin
                req_mem_ld <= issue;
            end
            // hand over on slice expiry or when the owner goes quiet
            if (want_other && (slice_over || !want_own)) begin
                owner     <= (owner == TAG_INDEX) ? TAG_VALUE : TAG_INDEX;
                slice_cnt <= '0;
            end else if (slice_over) begin
                slice_cnt <= '0;
            end else begin
                slice_cnt <= slice_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_mem_addr <= own_addr;
            req_mem_tag  <= owner;
        end
    end

endmodule

`default_nettype wire

// File: fetch_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fetch_port_if;
    import smac_pkg::*;

    logic      want;
    mem_addr_t addr;
    logic      grant;
    logic      at_end;

    modport fetcher (output want, output addr, output at_end, input grant);

    modport arbiter (input want, input addr, output grant);

    // completion watch only
    modport monitor (input at_end);

endinterface

`default_nettype wire

// File: index_builder.sv
`timescale 1ns/1ns
`default_nettype none

`include "sparse_decoder_consts.svh"

module index_builder (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        soft_rst,
    input  wire smac_pkg::reg_load_t   load,
    input  wire stream_pkg::index_word_t word,
    input  wire                        empty,
    input  wire                        stall_index,
    output logic                       pop,
    output logic                       push_index,
    output stream_pkg::coord_t         row,
    output stream_pkg::coord_t         col,
    output logic                       done
);
    import smac_pkg::*;
    import stream_pkg::*;

    localparam reg_sel_t COUNT_SEL = reg_sel_t'(4);

    logic [`SMD_ADDR_W-1:0] count;
    logic        s1_valid;
    index_code_t s1_code;
    coord_t      s1_delta;
    logic        s2_valid;
    index_code_t s2_code;
    coord_t      s2_step;

    // count is the number of coordinates still to push
    assign pop  = !empty && !stall_index && count != '0;
    assign done = count == '0 && !s1_valid && !s2_valid;

    always_ff @(posedge clk) begin
        s1_code  <= word.code;
        s1_delta <= word.delta;
        s2_code  <= s1_code;
        s2_step  <= s1_delta + coord_t'(1);
    end

    always_ff @(posedge clk) begin
        if (rst || soft_rst) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            push_index <= 1'b0;
            row        <= '0;
            col        <= '1;
            count      <= '0;
        end else begin
            s1_valid   <= pop;
            s2_valid   <= s1_valid;
            push_index <= 1'b0;
            if (s2_valid) begin
                if (s2_code == CODE_DELTA) begin
                    col <= col + s2_step;
                    // words past the count still move col but never push
                    if (count != '0) begin
                        push_index <= 1'b1;
                        count      <= count - 1'b1;
                    end
                end else if (s2_code == CODE_NEWLINE) begin
                    row <= row + coord_t'(1);
                    col <= '1;
                end
            end
            if (load.valid && load.sel == COUNT_SEL) begin
                count <= load.value;
            end
        end
    end

endmodule

`default_nettype wire

// File: response_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "sparse_decoder_consts.svh"

module response_fifo #(
    parameter type payload_t = logic [`SMD_DATA_W-1:0]
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           push,
    input  wire payload_t din,
    input  wire           pop,
    output payload_t      dout,
    output logic          empty
);
    localparam int DEPTH = `SMD_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_pop;

    assign empty  = count == '0;
    assign do_pop = pop && !empty;
    // show-ahead read, head word visible while not empty
    assign dout   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: smac_pkg.sv
`default_nettype none

`include "sparse_decoder_consts.svh"

package smac_pkg;

    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_RST    = 4'd1,
        OP_LD     = 4'd2,
        OP_STEADY = 4'd3
    } opcode_t;

    typedef logic [`SMD_ADDR_W-1:0] mem_addr_t;

    // tag carried with each request and echoed on the response
    typedef enum logic {
        TAG_INDEX = 1'b0,
        TAG_VALUE = 1'b1
    } mem_tag_t;

    // 0/1 start pointers, 2/3 end pointers, 4/5 output counts
    typedef logic [3:0] reg_sel_t;

    typedef struct packed {
        logic      valid;
        reg_sel_t  sel;
        mem_addr_t value;
    } reg_load_t;

endpackage

`default_nettype wire

// File: sparse_decoder_consts.svh
`ifndef SPARSE_DECODER_CONSTS_SVH
`define SPARSE_DECODER_CONSTS_SVH

// memory port widths
`define SMD_ADDR_W 48
`define SMD_DATA_W 64

// words per response FIFO, also the credit limit of each fetcher
`define SMD_FIFO_DEPTH 16

// cycles one fetcher may own the request port
`define SMD_SLICE_CYCLES 32

// command word layout
// opcode sits below ARG_PE, broadcast bit just below ARG_1
`define SMD_OP_ARG_PE 4
`define SMD_OP_ARG_1 12
`define SMD_OP_ARG_2 16

`endif

// File: sparse_matrix_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "sparse_decoder_consts.svh"

module sparse_matrix_decoder #(
    parameter int PE_ID = 0
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [`SMD_DATA_W-1:0]    op,
    output logic                     busy,
    output logic                     req_mem_ld,
    output smac_pkg::mem_addr_t      req_mem_addr,
    output smac_pkg::mem_tag_t       req_mem_tag,
    input  wire                      req_mem_stall,
    input  wire                      rsp_mem_push,
    input  wire smac_pkg::mem_tag_t  rsp_mem_tag,
    input  wire [`SMD_DATA_W-1:0]    rsp_mem_q,
    output logic                     push_index,
    output stream_pkg::coord_t       row,
    output stream_pkg::coord_t       col,
    input  wire                      stall_index,
    output logic                     push_val,
    output stream_pkg::value_word_t  val,
    input  wire                      stall_val
);
    import smac_pkg::*;
    import stream_pkg::*;

    reg_load_t   load;
    logic        streaming;
    logic        soft_rst;
    logic        idx_done;
    logic        val_done;
    index_word_t idx_word;
    value_word_t val_word;
    logic        idx_empty;
    logic        val_empty;
    logic        idx_pop;
    logic        val_pop;

    // port_a walks the index stream, port_b the value stream
    fetch_port_if port_a ();
    fetch_port_if port_b ();

    command_decoder #(.PE_ID(PE_ID)) i_cmd (
        .clk(clk), .rst(rst), .op(op), .idx_done(idx_done), .val_done(val_done),
        .port_a(port_a.monitor), .port_b(port_b.monitor), .load(load),
        .streaming(streaming), .busy(busy), .soft_rst(soft_rst)
    );

    stream_fetcher #(.STREAM(0)) i_idx_fetch (
        .clk(clk), .rst(rst), .soft_rst(soft_rst), .load(load),
        .streaming(streaming), .credit_back(idx_pop), .port(port_a.fetcher)
    );

    stream_fetcher #(.STREAM(1)) i_val_fetch (
        .clk(clk), .rst(rst), .soft_rst(soft_rst), .load(load),
        .streaming(streaming), .credit_back(val_pop), .port(port_b.fetcher)
    );

    fetch_arbiter i_arb (
        .clk(clk), .rst(rst), .req_mem_stall(req_mem_stall),
        .port_a(port_a.arbiter), .port_b(port_b.arbiter), .req_mem_ld(req_mem_ld),
        .req_mem_addr(req_mem_addr), .req_mem_tag(req_mem_tag)
    );

    // responses steered by tag, FIFOs flushed with the soft reset
    response_fifo #(.payload_t(index_word_t)) i_idx_fifo (
        .clk(clk), .rst(rst || soft_rst), .push(rsp_mem_push && rsp_mem_tag == TAG_INDEX),
        .din(index_word_t'(rsp_mem_q)), .pop(idx_pop), .dout(idx_word), .empty(idx_empty)
    );

    response_fifo #(.payload_t(value_word_t)) i_val_fifo (
        .clk(clk), .rst(rst || soft_rst), .push(rsp_mem_push && rsp_mem_tag == TAG_VALUE),
        .din(rsp_mem_q), .pop(val_pop), .dout(val_word), .empty(val_empty)
    );

    index_builder i_idx (
        .clk(clk), .rst(rst), .soft_rst(soft_rst), .load(load), .word(idx_word),
        .empty(idx_empty), .stall_index(stall_index), .pop(idx_pop),
        .push_index(push_index), .row(row), .col(col), .done(idx_done)
    );

    value_drain i_val (
        .clk(clk), .rst(rst), .soft_rst(soft_rst), .load(load), .word(val_word),
        .empty(val_empty), .stall_val(stall_val), .pop(val_pop),
        .push_val(push_val), .val(val), .done(val_done)
    );

endmodule

`default_nettype wire

// File: src.f
+incdir+.
smac_pkg.sv
stream_pkg.sv
fetch_port_if.sv
command_decoder.sv
stream_fetcher.sv
fetch_arbiter.sv
response_fifo.sv
index_builder.sv
value_drain.sv
sparse_matrix_decoder.sv
tb_sparse_matrix_decoder.sv

// File: stream_fetcher.sv
`timescale 1ns/1ns
`default_nettype none

`include "sparse_decoder_consts.svh"

module stream_fetcher #(
    parameter int STREAM = 0
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     soft_rst,
    input  wire smac_pkg::reg_load_t load,
    input  wire                     streaming,
    input  wire                     credit_back,
    fetch_port_if.fetcher           port
);
    import smac_pkg::*;

    // start pointer in register STREAM, end pointer two above it
    localparam reg_sel_t START_SEL = reg_sel_t'(STREAM);
    localparam reg_sel_t END_SEL   = reg_sel_t'(STREAM + 2);
    localparam int CW = $clog2(`SMD_FIFO_DEPTH + 1);

    mem_addr_t     ptr;
    mem_addr_t     end_ptr;
    logic [CW-1:0] credits;
    logic          at_end;

    assign at_end      = ptr == end_ptr;
    assign port.at_end = at_end;
    assign port.addr   = ptr;
    // one credit per free FIFO slot, so a response always has room
    assign port.want   = streaming && !at_end && credits != '0;

    always_ff @(posedge clk) begin
        if (rst || soft_rst) begin
            ptr     <= '0;
            end_ptr <= '0;
            credits <= CW'(`SMD_FIFO_DEPTH);
        end else begin
            if (load.valid && load.sel == START_SEL) begin
                ptr <= load.value;
            end else if (port.grant) begin
                ptr <= ptr + mem_addr_t'(8);
            end
            if (load.valid && load.sel == END_SEL) begin
                end_ptr <= load.value;
            end
            case ({port.grant, credit_back})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: stream_pkg.sv
`default_nettype none

`include "sparse_decoder_consts.svh"

package stream_pkg;

    typedef enum logic [1:0] {
        CODE_NEWLINE = 2'd0,
        CODE_DELTA   = 2'd1
    } index_code_t;

    // pre-decoded index word, delta is the column gap minus one
    typedef struct packed {
        logic [`SMD_DATA_W-35:0] unused;
        logic [31:0]             delta;
        index_code_t             code;
    } index_word_t;

    typedef logic [`SMD_DATA_W-1:0] value_word_t;

    typedef logic [31:0] coord_t;

endpackage

`default_nettype wire

// File: tb_sparse_matrix_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sparse_matrix_decoder;
    import smac_pkg::*;

    localparam logic [47:0] IDX_BASE = 48'h100;
    localparam logic [47:0] VAL_BASE = 48'h800;
    localparam int IDX_WORDS = 40;
    localparam int VAL_COUNT = 24;
    localparam int MAX_CYCLES = 20000;

    logic clk;
    logic rst;
    logic [63:0] op;
    logic busy;
    logic req_mem_ld;
    mem_addr_t req_mem_addr;
    mem_tag_t req_mem_tag;
    logic req_mem_stall;
    logic rsp_mem_push;
    mem_tag_t rsp_mem_tag;
    logic [63:0] rsp_mem_q;
    logic push_index;
    logic [31:0] row;
    logic [31:0] col;
    logic stall_index;
    logic push_val;
    logic [63:0] val;
    logic stall_val;

    logic [31:0] lfsr = 32'he172;
    logic [63:0] mem_words [0:511];
    logic [31:0] exp_row [0:IDX_WORDS-1];
    logic [31:0] exp_col [0:IDX_WORDS-1];
    int idx_count;
    int idx_seen;
    int val_seen;
    int cycle;
    int addr_errors;
    int idx_errors;
    int val_errors;
    int ctl_errors;
    logic idle_expected;
    logic mute;
    mem_addr_t exp_addr [2];
    mem_addr_t end_addr [2];
    mem_addr_t q_addr [$];
    logic q_tag [$];
    int q_due [$];
    int last_due;
    logic prev_hold;
    mem_addr_t prev_addr;
    mem_tag_t prev_tag;

    sparse_matrix_decoder #(.PE_ID(3)) i_dut (
        .clk(clk), .rst(rst), .op(op), .busy(busy), .req_mem_ld(req_mem_ld),
        .req_mem_addr(req_mem_addr), .req_mem_tag(req_mem_tag),
        .req_mem_stall(req_mem_stall), .rsp_mem_push(rsp_mem_push),
        .rsp_mem_tag(rsp_mem_tag), .rsp_mem_q(rsp_mem_q), .push_index(push_index),
        .row(row), .col(col), .stall_index(stall_index), .push_val(push_val),
        .val(val), .stall_val(stall_val)
    );

    // galois LFSR stepped once for each bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [63:0] make_cmd(input logic [3:0] opc, input logic [6:0] pe,
                                             input logic bc, input logic [3:0] sel,
                                             input logic [47:0] value);
        return {value, sel, bc, pe, opc};
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // memory model with random stalls and request port checks
    always @(posedge clk) begin
        int delay;
        int due;
        int slot;
        if (prev_hold) begin
            assert (req_mem_ld && req_mem_addr == prev_addr && req_mem_tag == prev_tag)
            else begin
                ctl_errors++;
                $display("stalled request changed before memory took it");
            end
        end
        prev_hold <= req_mem_ld && req_mem_stall;
        prev_addr <= req_mem_addr;
        prev_tag  <= req_mem_tag;
        rsp_mem_push <= 1'b0;
        if (mute) begin
            q_addr.delete();
            q_tag.delete();
            q_due.delete();
        end else begin
            if (req_mem_ld && !req_mem_stall) begin
                assert (req_mem_addr == exp_addr[req_mem_tag])
                else begin
                    addr_errors++;
                    $display("ERROR fetch_order: expected %h actual %h",
                             exp_addr[req_mem_tag], req_mem_addr);
                end
                assert (req_mem_addr < end_addr[req_mem_tag])
                else begin
                    addr_errors++;
                    $display("request at %h is past the end pointer", req_mem_addr);
                end
                exp_addr[req_mem_tag] = exp_addr[req_mem_tag] + 48'd8;
                delay = int'(take_bits(3)) + 1;
                due = cycle + delay;
                if (due <= last_due) due = last_due + 1;
                last_due = due;
                q_addr.push_back(req_mem_addr);
                q_tag.push_back(req_mem_tag);
                q_due.push_back(due);
            end
            if (q_due.size() > 0 && q_due[0] <= cycle) begin
                slot = int'(q_addr[0][11:3]);
                rsp_mem_push <= 1'b1;
                rsp_mem_tag  <= mem_tag_t'(q_tag[0]);
                rsp_mem_q    <= mem_words[slot];
                void'(q_addr.pop_front());
                void'(q_tag.pop_front());
                void'(q_due.pop_front());
            end
        end
        req_mem_stall <= take_bits(2) == 32'd3;
        stall_index   <= take_bits(1) == 32'd1;
        stall_val     <= take_bits(1) == 32'd1;
    end

    // output checks
    always @(posedge clk) begin
        if (idle_expected) begin
            assert (!busy && !req_mem_ld && !push_index && !push_val)
            else begin
                ctl_errors++;
                $display("unit is active while it should be idle");
            end
        end
        if (push_index) begin
            assert (idx_seen < idx_count && row == exp_row[idx_seen] && col == exp_col[idx_seen])
            else begin
                idx_errors++;
                $display("ERROR index_decode: expected %0d,%0d actual %0d,%0d",
                         exp_row[idx_seen], exp_col[idx_seen], row, col);
            end
            idx_seen = idx_seen + 1;
        end
        if (push_val) begin
            assert (val_seen < VAL_COUNT && val == mem_words[int'(VAL_BASE >> 3) + val_seen])
            else begin
                val_errors++;
                $display("ERROR values: expected %h actual %h",
                         mem_words[int'(VAL_BASE >> 3) + val_seen], val);
            end
            val_seen = val_seen + 1;
        end
    end

    task automatic send_cmd(input logic [63:0] w);
        @(posedge clk);
        op <= w;
        @(posedge clk);
        op <= '0;
    endtask

    task automatic load_and_start(input logic filtered);
        idle_expected = 1'b1;
        idx_seen = 0;
        val_seen = 0;
        exp_addr[0] = IDX_BASE;
        exp_addr[1] = VAL_BASE;
        // coordinates restart from row 0 only on a reset
        send_cmd(make_cmd(OP_RST, 7'd3, 1'b0, 4'd0, 48'd0));
        send_cmd(make_cmd(OP_LD, 7'd3, 1'b0, 4'd0, IDX_BASE));
        send_cmd(make_cmd(OP_LD, 7'd3, 1'b0, 4'd1, VAL_BASE));
        send_cmd(make_cmd(OP_LD, 7'd3, 1'b0, 4'd2, end_addr[0]));
        send_cmd(make_cmd(OP_LD, 7'd3, 1'b0, 4'd3, end_addr[1]));
        send_cmd(make_cmd(OP_LD, 7'd3, 1'b0, 4'd4, 48'(idx_count)));
        // value count as a broadcast to another id
        send_cmd(make_cmd(OP_LD, 7'd0, 1'b1, 4'd5, 48'(VAL_COUNT)));
        if (filtered) begin
            send_cmd(make_cmd(OP_LD, 7'd5, 1'b0, 4'd4, 48'd3));
            send_cmd(make_cmd(OP_LD, 7'd5, 1'b0, 4'd3, VAL_BASE));
        end
        @(posedge clk);
        idle_expected = 1'b0;
        send_cmd(make_cmd(OP_STEADY, 7'd3, 1'b0, 4'd0, 48'd0));
        @(posedge clk);
        assert (busy)
        else begin
            ctl_errors++;
            $display("busy did not rise after the steady command");
        end
    endtask

    task automatic run_to_done(input logic filtered);
        load_and_start(filtered);
        while (busy) @(posedge clk);
        assert (idx_seen == idx_count && val_seen == VAL_COUNT)
        else begin
            ctl_errors++;
            $display("busy fell with %0d of %0d coordinates and %0d of %0d values",
                     idx_seen, idx_count, val_seen, VAL_COUNT);
        end
        @(posedge clk);
        idle_expected = 1'b1;
        repeat (10) @(posedge clk);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] c;
        logic [63:0] w;
        rst = 1'b1;
        op = '0;
        req_mem_stall = 1'b0;
        rsp_mem_push = 1'b0;
        rsp_mem_tag = TAG_INDEX;
        rsp_mem_q = '0;
        stall_index = 1'b0;
        stall_val = 1'b0;
        cycle = 0;
        addr_errors = 0;
        idx_errors = 0;
        val_errors = 0;
        ctl_errors = 0;
        idle_expected = 1'b0;
        mute = 1'b0;
        prev_hold = 1'b0;
        last_due = 0;
        idx_count = 0;
        idx_seen = 0;
        val_seen = 0;
        for (int i = 0; i < 512; i++) begin
            mem_words[i] = {i[15:0], 16'hc0de, ~i[31:0]};
        end
        // about one index word in four is a newline and the last is a delta
        r = 0;
        c = 32'hffffffff;
        for (int i = 0; i < IDX_WORDS; i++) begin
            w = '0;
            w[5:2] = 4'(take_bits(4));
            if (take_bits(2) == 32'd3 && i != IDX_WORDS - 1) begin
                w[1:0] = 2'd0;
                r = r + 1;
                c = 32'hffffffff;
            end else begin
                w[1:0] = 2'd1;
                c = c + w[33:2] + 1;
                exp_row[idx_count] = r;
                exp_col[idx_count] = c;
                idx_count++;
            end
            mem_words[int'(IDX_BASE >> 3) + i] = w;
        end
        for (int i = 0; i < VAL_COUNT; i++) begin
            mem_words[int'(VAL_BASE >> 3) + i] = {take_bits(32), take_bits(32)};
        end
        end_addr[0] = IDX_BASE + 48'(IDX_WORDS * 8);
        end_addr[1] = VAL_BASE + 48'(VAL_COUNT * 8);
        repeat (2) @(posedge clk);
        idle_expected = 1'b1;
        repeat (6) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        run_to_done(1'b1);

        // soft reset in the middle of a stream
        load_and_start(1'b0);
        while (idx_seen < 5) @(posedge clk);
        mute = 1'b1;
        send_cmd(make_cmd(OP_RST, 7'd3, 1'b0, 4'd0, 48'd0));
        repeat (20) @(posedge clk);
        assert (!busy && row == 32'd0 && col == 32'hffffffff)
        else begin
            ctl_errors++;
            $display("soft reset left busy %0b at row %0d col %0d", busy, row, col);
        end
        mute = 1'b0;
        last_due = cycle;

        run_to_done(1'b0);

        $display("errors: address %0d, index %0d, value %0d, control %0d",
                 addr_errors, idx_errors, val_errors, ctl_errors);
        if (addr_errors + idx_errors + val_errors + ctl_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: value_drain.sv
`timescale 1ns/1ns
`default_nettype none

`include "sparse_decoder_consts.svh"

module value_drain (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         soft_rst,
    input  wire smac_pkg::reg_load_t    load,
    input  wire stream_pkg::value_word_t word,
    input  wire                         empty,
    input  wire                         stall_val,
    output logic                        pop,
    output logic                        push_val,
    output stream_pkg::value_word_t     val,
    output logic                        done
);
    import smac_pkg::*;

    localparam reg_sel_t COUNT_SEL = reg_sel_t'(5);

    logic [`SMD_ADDR_W-1:0] count;

    assign pop  = !empty && !stall_val && count != '0;
    assign done = count == '0 && !push_val;

    always_ff @(posedge clk) begin
        if (pop) begin
            val <= word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || soft_rst) begin
            push_val <= 1'b0;
            count    <= '0;
        end else begin
            push_val <= pop;
            if (load.valid && load.sel == COUNT_SEL) begin
                count <= load.value;
            end else if (pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
